/* logic/immu_pkg.sv */
/*
 Instruction MMU definitions
 Widths, SPR map, TLB entry and PTE bit positions, and the structs
 passed between the register block, TLB storage, lookup and walker
*/
package immu_pkg;

   localparam int WORD_W     = 32;
   localparam int SPR_ADDR_W = 16;
   localparam int SET_W      = 6;
   localparam int TLB_SETS   = 1 << SET_W;
   localparam int PAGE_LSB   = 13;
   localparam int PN_W       = WORD_W - PAGE_LSB;

   typedef logic [WORD_W-1:0]     word_t;
   typedef logic [SPR_ADDR_W-1:0] spr_addr_t;
   typedef logic [SET_W-1:0]      set_idx_t;
   typedef logic [PN_W-1:0]       pn_t;

   // SPR map of group 2, each TLB region spans one address per set
   localparam spr_addr_t  SPR_IMMUCR       = 16'h1000;
   localparam spr_addr_t  SPR_ITLB_MR_BASE = 16'h1200;
   localparam spr_addr_t  SPR_ITLB_TR_BASE = 16'h1280;
   localparam logic [4:0] SPR_GROUP_IMMU   = 5'd2;

   // IMMUCR page table base and directory index position
   localparam int PT_BASE_LSB = 10;
   localparam int DIR_IDX_LSB = 24;

   // Match word
   localparam int MR_V_BIT = 0;

   // Translate word
   localparam int TR_UXE_BIT = 7;
   localparam int TR_SXE_BIT = 6;
   localparam int TR_CI_BIT  = 1;
   localparam int ATTR_W     = 6;

   // Page table entry
   localparam int PTE_PRESENT_BIT = 10;
   localparam int PTE_X_BIT       = 8;
   localparam int PTE_U_BIT       = 6;

   typedef struct packed {
      spr_addr_t addr;
      logic      we;
      logic      stb;
      word_t     dat;
   } spr_req_t;

   typedef struct packed {
      logic     we;
      set_idx_t idx;
      logic     sel_match;
      logic     sel_trans;
      word_t    match;
      word_t    trans;
   } tlb_wr_t;

   typedef struct packed {
      logic  valid;
      word_t vaddr;
      word_t paddr;
      logic  miss;
      logic  pagefault;
      logic  cache_inhibit;
   } lookup_res_t;

   typedef enum logic [1:0] {
      WALK_IDLE,
      WALK_DIR,
      WALK_PTE,
      WALK_SETTLE
   } walk_state_e;

endpackage

/* logic/itlb_ram.sv */
/*
 Instruction TLB storage
 Match and translate arrays of 64 sets, one shared write port,
 registered read ports for SPR access and for fetch lookup
*/
`timescale 1ns/100ps

module itlb_ram (
   input  logic               clk,
   input  immu_pkg::tlb_wr_t  wr_i,
   input  immu_pkg::set_idx_t spr_idx_i,
   output immu_pkg::word_t    spr_match_o,
   output immu_pkg::word_t    spr_trans_o,
   input  immu_pkg::set_idx_t look_idx_i,
   output immu_pkg::word_t    look_match_o,
   output immu_pkg::word_t    look_trans_o
);
   import immu_pkg::*;

   word_t match_mem [0:TLB_SETS-1];
   word_t trans_mem [0:TLB_SETS-1];

   // Either array or both may be written in one cycle
   always_ff @(posedge clk) begin
      if (wr_i.we && wr_i.sel_match) begin
         match_mem[wr_i.idx] <= wr_i.match;
      end
      if (wr_i.we && wr_i.sel_trans) begin
         trans_mem[wr_i.idx] <= wr_i.trans;
      end
   end

   // Reads return the old word when the same set is written
   always_ff @(posedge clk) begin
      spr_match_o  <= match_mem[spr_idx_i];
      spr_trans_o  <= trans_mem[spr_idx_i];
      look_match_o <= match_mem[look_idx_i];
      look_trans_o <= trans_mem[look_idx_i];
   end

endmodule

/* logic/immu_spr_regs.sv */
/*
 IMMU SPR register block
 Group 2 decode with one-cycle acknowledge, read-data mux, the
 IMMUCR register and the merge of SPR and walker TLB writes
*/
`timescale 1ns/100ps

module immu_spr_regs (
   input  logic               clk,
   input  logic               rst,
   input  immu_pkg::spr_req_t spr_i,
   output logic               spr_ack_o,
   output immu_pkg::word_t    spr_dat_o,
   input  immu_pkg::tlb_wr_t  walk_wr_i,
   output immu_pkg::tlb_wr_t  tlb_wr_o,
   output immu_pkg::set_idx_t spr_idx_o,
   input  immu_pkg::word_t    spr_match_i,
   input  immu_pkg::word_t    spr_trans_i,
   output immu_pkg::word_t    pt_base_o
);
   import immu_pkg::*;

   logic    grp_hit;
   logic    acc_go;
   logic    cr_cs;
   logic    mr_cs;
   logic    tr_cs;
   logic    ack_q;
   logic    cr_sel_q;
   logic    mr_sel_q;
   logic    tr_sel_q;
   word_t   immucr_q;
   tlb_wr_t spr_wr;

   assign grp_hit = spr_i.stb && (spr_i.addr[15:11] == SPR_GROUP_IMMU);

   // Access happens in the first strobe cycle only, the strobe is
   // still held while the acknowledge is out
   assign acc_go = grp_hit && !ack_q;

   assign cr_cs = (spr_i.addr == SPR_IMMUCR);
   assign mr_cs = (spr_i.addr[SPR_ADDR_W-1:SET_W] == SPR_ITLB_MR_BASE[SPR_ADDR_W-1:SET_W]);
   assign tr_cs = (spr_i.addr[SPR_ADDR_W-1:SET_W] == SPR_ITLB_TR_BASE[SPR_ADDR_W-1:SET_W]);

   // RAM read index follows the address so data is ready at the ack
   assign spr_idx_o = spr_i.addr[SET_W-1:0];

   always_ff @(posedge clk) begin
      if (rst) begin
         ack_q    <= 1'b0;
         cr_sel_q <= 1'b0;
         mr_sel_q <= 1'b0;
         tr_sel_q <= 1'b0;
         immucr_q <= '0;
      end else begin
         ack_q    <= acc_go;
         cr_sel_q <= acc_go && cr_cs;
         mr_sel_q <= acc_go && mr_cs;
         tr_sel_q <= acc_go && tr_cs;
         if (acc_go && spr_i.we && cr_cs) begin
            immucr_q <= spr_i.dat;
         end
      end
   end

   assign spr_ack_o = ack_q;
   assign pt_base_o = immucr_q;

   // Unmapped group 2 addresses fall through to zero
   always_comb begin
      spr_dat_o = '0;
      if (mr_sel_q) begin
         spr_dat_o = spr_match_i;
      end else if (tr_sel_q) begin
         spr_dat_o = spr_trans_i;
      end else if (cr_sel_q) begin
         spr_dat_o = immucr_q;
      end
   end

   always_comb begin
      spr_wr.we        = acc_go && spr_i.we && (mr_cs || tr_cs);
      spr_wr.idx       = spr_i.addr[SET_W-1:0];
      spr_wr.sel_match = mr_cs;
      spr_wr.sel_trans = tr_cs;
      spr_wr.match     = spr_i.dat;
      spr_wr.trans     = spr_i.dat;
   end

   // Walker refill wins over software
   assign tlb_wr_o = walk_wr_i.we ? walk_wr_i : spr_wr;

endmodule

/* logic/itlb_lookup.sv */
/*
 Instruction TLB lookup
 Set index goes to the RAM in the fetch cycle, tag compare,
 translation and permission check follow one cycle later
*/
`timescale 1ns/100ps

module itlb_lookup (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  fetch_valid_i,
   input  immu_pkg::word_t       fetch_vaddr_i,
   input  logic                  supervisor_i,
   input  logic                  blocked_i,
   output immu_pkg::set_idx_t    look_idx_o,
   input  immu_pkg::word_t       look_match_i,
   input  immu_pkg::word_t       look_trans_i,
   output immu_pkg::lookup_res_t res_o
);
   import immu_pkg::*;

   logic  go;
   logic  valid_q;
   word_t vaddr_q;
   logic  sup_q;
   pn_t   tag;
   logic  hit;
   logic  exec_ok;

   // Fetches during a refill are dropped
   assign go = fetch_valid_i && !blocked_i;

   assign look_idx_o = fetch_vaddr_i[PAGE_LSB +: SET_W];

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= go;
      end
   end

   always_ff @(posedge clk) begin
      if (go) begin
         vaddr_q <= fetch_vaddr_i;
         sup_q   <= supervisor_i;
      end
   end

   assign tag     = look_match_i[WORD_W-1:PAGE_LSB];
   assign hit     = look_match_i[MR_V_BIT] && (tag == vaddr_q[WORD_W-1:PAGE_LSB]);
   // Supervisor uses SXE, user mode UXE
   assign exec_ok = sup_q ? look_trans_i[TR_SXE_BIT] : look_trans_i[TR_UXE_BIT];

   always_comb begin
      res_o.valid         = valid_q;
      res_o.vaddr         = vaddr_q;
      res_o.paddr         = {look_trans_i[WORD_W-1:PAGE_LSB], vaddr_q[PAGE_LSB-1:0]};
      res_o.miss          = valid_q && !hit;
      res_o.pagefault     = valid_q && hit && !exec_ok;
      res_o.cache_inhibit = look_trans_i[TR_CI_BIT];
   end

endmodule

/* logic/itlb_reload_walker.sv */
/*
 Instruction TLB reload walker
 Two-level page table walk after a TLB miss, converts the PTE into
 match and translate words, sticky fault on a missing page
*/
`timescale 1ns/100ps

module itlb_reload_walker (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  enable_i,
   input  immu_pkg::lookup_res_t res_i,
   input  immu_pkg::word_t       pt_base_i,
   output logic                  mem_req_o,
   output immu_pkg::word_t       mem_addr_o,
   input  logic                  mem_ack_i,
   input  immu_pkg::word_t       mem_rdata_i,
   output immu_pkg::tlb_wr_t     walk_wr_o,
   output logic                  busy_o,
   output logic                  done_o,
   output logic                  fault_o,
   input  logic                  fault_clear_i
);
   import immu_pkg::*;

   walk_state_e state_q;
   logic        req_q;
   logic        wr_we_q;
   logic        done_q;
   logic        fault_q;
   logic        start;
   pn_t         ptr_pn;
   word_t       addr_q;
   word_t       vaddr_q;
   word_t       trans_q;
   word_t       match_new;
   word_t       trans_new;

   // No new walk while a fault is pending
   assign start = enable_i && res_i.valid && res_i.miss && !fault_q &&
                  (pt_base_i[WORD_W-1:PT_BASE_LSB] != '0);

   assign ptr_pn = mem_rdata_i[WORD_W-1:PAGE_LSB];

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= WALK_IDLE;
         req_q   <= 1'b0;
         wr_we_q <= 1'b0;
         done_q  <= 1'b0;
         fault_q <= 1'b0;
      end else begin
         wr_we_q <= 1'b0;
         done_q  <= 1'b0;
         if (fault_clear_i) begin
            fault_q <= 1'b0;
         end
         case (state_q)
            WALK_IDLE: begin
               if (start) begin
                  req_q   <= 1'b1;
                  state_q <= WALK_DIR;
               end
            end
            // Request stays up across the two reads
            WALK_DIR: begin
               if (mem_ack_i) begin
                  if (ptr_pn == '0) begin
                     req_q   <= 1'b0;
                     fault_q <= 1'b1;
                     state_q <= WALK_IDLE;
                  end else begin
                     state_q <= WALK_PTE;
                  end
               end
            end
            WALK_PTE: begin
               if (mem_ack_i) begin
                  req_q <= 1'b0;
                  if (!mem_rdata_i[PTE_PRESENT_BIT]) begin
                     fault_q <= 1'b1;
                     state_q <= WALK_IDLE;
                  end else begin
                     wr_we_q <= 1'b1;
                     state_q <= WALK_SETTLE;
                  end
               end
            end
            // Entry is written here, lookups see it from the next cycle
            WALK_SETTLE: begin
               done_q  <= 1'b1;
               state_q <= WALK_IDLE;
            end
            default: begin
               state_q <= WALK_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == WALK_IDLE && start) begin
         vaddr_q <= res_i.vaddr;
         addr_q  <= {pt_base_i[WORD_W-1:PT_BASE_LSB],
                     res_i.vaddr[WORD_W-1:DIR_IDX_LSB], 2'b00};
      end else if (state_q == WALK_DIR && mem_ack_i) begin
         addr_q <= {ptr_pn, vaddr_q[DIR_IDX_LSB-1:PAGE_LSB], 2'b00};
      end
      if (state_q == WALK_PTE && mem_ack_i) begin
         trans_q <= trans_new;
      end
   end

   // PTE to TLB entry, UXE needs both X and U
   always_comb begin
      match_new                          = '0;
      match_new[WORD_W-1:PAGE_LSB]       = vaddr_q[WORD_W-1:PAGE_LSB];
      match_new[MR_V_BIT]                = 1'b1;
      trans_new                          = '0;
      trans_new[WORD_W-1:PAGE_LSB]       = mem_rdata_i[WORD_W-1:PAGE_LSB];
      trans_new[TR_UXE_BIT]              = mem_rdata_i[PTE_X_BIT] && mem_rdata_i[PTE_U_BIT];
      trans_new[TR_SXE_BIT]              = mem_rdata_i[PTE_X_BIT];
      trans_new[ATTR_W-1:0]              = mem_rdata_i[ATTR_W-1:0];
   end

   always_comb begin
      walk_wr_o.we        = wr_we_q;
      walk_wr_o.idx       = vaddr_q[PAGE_LSB +: SET_W];
      walk_wr_o.sel_match = 1'b1;
      walk_wr_o.sel_trans = 1'b1;
      walk_wr_o.match     = match_new;
      walk_wr_o.trans     = trans_q;
   end

   assign mem_req_o  = req_q;
   assign mem_addr_o = addr_q;
   assign busy_o     = (state_q != WALK_IDLE);
   assign done_o     = done_q;
   assign fault_o    = fault_q;

endmodule

/* logic/immu_top.sv */
/*
 Instruction MMU top level
 SPR register block, TLB storage, fetch lookup and reload walker
*/
`timescale 1ns/100ps

module immu_top (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  enable_i,
   input  logic                  supervisor_i,
   input  logic                  fetch_valid_i,
   input  immu_pkg::word_t       fetch_vaddr_i,
   output immu_pkg::lookup_res_t res_o,
   input  immu_pkg::spr_req_t    spr_i,
   output logic                  spr_ack_o,
   output immu_pkg::word_t       spr_dat_o,
   output logic                  mem_req_o,
   output immu_pkg::word_t       mem_addr_o,
   input  logic                  mem_ack_i,
   input  immu_pkg::word_t       mem_rdata_i,
   output logic                  reload_busy_o,
   output logic                  reload_done_o,
   output logic                  reload_fault_o,
   input  logic                  reload_fault_clear_i
);
   import immu_pkg::*;

   tlb_wr_t  walk_wr;
   tlb_wr_t  tlb_wr;
   set_idx_t spr_idx;
   set_idx_t look_idx;
   word_t    spr_match;
   word_t    spr_trans;
   word_t    look_match;
   word_t    look_trans;
   word_t    pt_base;

   immu_spr_regs u_spr_regs (
      .clk         (clk),
      .rst         (rst),
      .spr_i       (spr_i),
      .spr_ack_o   (spr_ack_o),
      .spr_dat_o   (spr_dat_o),
      .walk_wr_i   (walk_wr),
      .tlb_wr_o    (tlb_wr),
      .spr_idx_o   (spr_idx),
      .spr_match_i (spr_match),
      .spr_trans_i (spr_trans),
      .pt_base_o   (pt_base)
   );

   itlb_ram u_itlb_ram (
      .clk          (clk),
      .wr_i         (tlb_wr),
      .spr_idx_i    (spr_idx),
      .spr_match_o  (spr_match),
      .spr_trans_o  (spr_trans),
      .look_idx_i   (look_idx),
      .look_match_o (look_match),
      .look_trans_o (look_trans)
   );

   // Lookups are held off for the length of a refill
   itlb_lookup u_itlb_lookup (
      .clk           (clk),
      .rst           (rst),
      .fetch_valid_i (fetch_valid_i),
      .fetch_vaddr_i (fetch_vaddr_i),
      .supervisor_i  (supervisor_i),
      .blocked_i     (reload_busy_o),
      .look_idx_o    (look_idx),
      .look_match_i  (look_match),
      .look_trans_i  (look_trans),
      .res_o         (res_o)
   );

   itlb_reload_walker u_walker (
      .clk           (clk),
      .rst           (rst),
      .enable_i      (enable_i),
      .res_i         (res_o),
      .pt_base_i     (pt_base),
      .mem_req_o     (mem_req_o),
      .mem_addr_o    (mem_addr_o),
      .mem_ack_i     (mem_ack_i),
      .mem_rdata_i   (mem_rdata_i),
      .walk_wr_o     (walk_wr),
      .busy_o        (reload_busy_o),
      .done_o        (reload_done_o),
      .fault_o       (reload_fault_o),
      .fault_clear_i (reload_fault_clear_i)
   );

endmodule

/* testbench/immu_tb.sv */
/*
 Instruction MMU testbench
 Directed tests for SPR access, TLB lookup, table walk refill and
 walk faults, with a stalling memory model behind the walker port
*/
`timescale 1ns/100ps

module immu_tb;
   import immu_pkg::*;

   localparam int CLK_PERIOD  = 40;
   // Rough cycle budget of all tests
   localparam int TEST_CYCLES = 400;
   localparam int WATCHDOG_NS = (TEST_CYCLES + 200) * CLK_PERIOD;
   localparam int ACK_LIMIT   = 8;
   localparam int WALK_LIMIT  = 40;

   logic        clk;
   logic        rst;
   logic        enable_i;
   logic        supervisor_i;
   logic        fetch_valid_i;
   word_t       fetch_vaddr_i;
   lookup_res_t res_o;
   spr_req_t    spr_i;
   logic        spr_ack_o;
   word_t       spr_dat_o;
   logic        mem_req_o;
   word_t       mem_addr_o;
   logic        mem_ack_i;
   word_t       mem_rdata_i;
   logic        reload_busy_o;
   logic        reload_done_o;
   logic        reload_fault_o;
   logic        reload_fault_clear_i;

   // Reference copy of the TLB kept by the tests
   word_t match_model [0:TLB_SETS-1];
   word_t trans_model [0:TLB_SETS-1];
   word_t mem [word_t];
   word_t walk_addrs [$];
   word_t fetch_va [$];
   logic  fetch_sup [$];
   word_t lfsr_state = 32'h3fa9;
   int    value_errors;
   int    other_errors;
   int    wait_left;

   immu_top dut (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   // Galois LFSR with one step per bit taken
   function automatic word_t rand_bits(input int n);
      word_t r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[WORD_W-2:0], lfsr_state[0]};
         if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
         end else begin
            lfsr_state = lfsr_state >> 1;
         end
      end
      return r;
   endfunction

   function automatic spr_addr_t match_spr(input set_idx_t s);
      return {SPR_ITLB_MR_BASE[SPR_ADDR_W-1:SET_W], s};
   endfunction

   function automatic spr_addr_t trans_spr(input set_idx_t s);
      return {SPR_ITLB_TR_BASE[SPR_ADDR_W-1:SET_W], s};
   endfunction

   // Expected lookup response from the reference TLB
   function automatic lookup_res_t expect_lookup(input word_t va, input logic sup);
      lookup_res_t r;
      word_t       m;
      word_t       t;
      logic        hit;
      m   = match_model[va[PAGE_LSB +: SET_W]];
      t   = trans_model[va[PAGE_LSB +: SET_W]];
      hit = m[MR_V_BIT] && (m[WORD_W-1:PAGE_LSB] == va[WORD_W-1:PAGE_LSB]);
      r.valid         = 1'b1;
      r.vaddr         = va;
      r.paddr         = {t[WORD_W-1:PAGE_LSB], va[PAGE_LSB-1:0]};
      r.miss          = !hit;
      r.pagefault     = hit && !(sup ? t[TR_SXE_BIT] : t[TR_UXE_BIT]);
      r.cache_inhibit = t[TR_CI_BIT];
      return r;
   endfunction

   task automatic tick();
      @(posedge clk);
      #5;
   endtask

   task automatic word_equal(input word_t got, input word_t want, input string what);
      if (got !== want) begin
         value_errors++;
         $display("Error at %0t: %s, expected %h, got %h", $time, what, want, got);
      end
   endtask

   task automatic flag_equal(input logic got, input logic want, input string what);
      if (got !== want) begin
         value_errors++;
         $display("Error at %0t: %s, expected %b, got %b", $time, what, want, got);
      end
   endtask

   task automatic result_equal(input lookup_res_t got, input lookup_res_t want,
                               input string what);
      if (got !== want) begin
         value_errors++;
         $display("Error at %0t: %s, expected v=%b va=%h pa=%h miss=%b pf=%b ci=%b",
                  $time, what, want.valid, want.vaddr, want.paddr, want.miss,
                  want.pagefault, want.cache_inhibit);
         $display("   got v=%b va=%h pa=%h miss=%b pf=%b ci=%b", got.valid, got.vaddr,
                  got.paddr, got.miss, got.pagefault, got.cache_inhibit);
      end
   endtask

   // Strobe held until the acknowledge that must come one cycle later
   task automatic spr_access(input spr_addr_t addr, input logic we, input word_t dat,
                             output word_t rdat);
      int waited;
      spr_i.addr = addr;
      spr_i.we   = we;
      spr_i.dat  = dat;
      spr_i.stb  = 1'b1;
      waited     = 0;
      tick();
      while (!spr_ack_o && waited < ACK_LIMIT) begin
         tick();
         waited++;
      end
      if (!spr_ack_o) begin
         other_errors++;
         $display("No SPR acknowledge for address %h", addr);
      end else if (waited != 0) begin
         other_errors++;
         $display("SPR acknowledge for address %h came %0d cycles late", addr, waited);
      end
      rdat      = spr_dat_o;
      spr_i.stb = 1'b0;
      spr_i.we  = 1'b0;
      tick();
      flag_equal(spr_ack_o, 1'b0, "acknowledge after one cycle");
   endtask

   task automatic spr_write(input spr_addr_t addr, input word_t dat);
      word_t unused;
      spr_access(addr, 1'b1, dat, unused);
   endtask

   task automatic spr_read_check(input spr_addr_t addr, input word_t want,
                                 input string what);
      word_t rdat;
      spr_access(addr, 1'b0, '0, rdat);
      word_equal(rdat, want, what);
   endtask

   task automatic load_entry(input set_idx_t s, input word_t m, input word_t t);
      spr_write(match_spr(s), m);
      spr_write(trans_spr(s), t);
      match_model[s] = m;
      trans_model[s] = t;
   endtask

   task automatic set_base(output word_t base);
      base = rand_bits(WORD_W);
      base[PT_BASE_LSB-1:0] = '0;
      base[WORD_W-1] = 1'b1;
      spr_write(SPR_IMMUCR, base);
      spr_read_check(SPR_IMMUCR, base, "IMMUCR readback");
   endtask

   // Back-to-back strobes with each result checked one cycle later
   task automatic issue_fetches();
      lookup_res_t want;
      for (int i = 0; i < fetch_va.size(); i++) begin
         fetch_valid_i = 1'b1;
         fetch_vaddr_i = fetch_va[i];
         supervisor_i  = fetch_sup[i];
         want = expect_lookup(fetch_va[i], fetch_sup[i]);
         tick();
         result_equal(res_o, want, "lookup result");
      end
      fetch_valid_i = 1'b0;
      fetch_va.delete();
      fetch_sup.delete();
   endtask

   // A fetch strobe during the refill must give no result
   task automatic busy_drop_check(input word_t va);
      tick();
      flag_equal(reload_busy_o, 1'b1, "busy during walk");
      fetch_valid_i = 1'b1;
      fetch_vaddr_i = va;
      tick();
      fetch_valid_i = 1'b0;
      flag_equal(res_o.valid, 1'b0, "result valid for a fetch during walk");
   endtask

   task automatic wait_walk_end(input logic want_fault);
      int n;
      n = 0;
      while (!reload_done_o && !reload_fault_o && n < WALK_LIMIT) begin
         tick();
         n++;
      end
      if (!reload_done_o && !reload_fault_o) begin
         other_errors++;
         $display("Table walk neither finished nor faulted in %0d cycles", WALK_LIMIT);
      end else begin
         flag_equal(reload_fault_o, want_fault, "reload fault at walk end");
         flag_equal(reload_done_o, !want_fault, "reload done at walk end");
      end
      tick();
      flag_equal(reload_done_o, 1'b0, "done pulse length");
      flag_equal(reload_busy_o, 1'b0, "busy after walk");
   endtask

   task automatic reset_state_check();
      flag_equal(res_o.valid, 1'b0, "result valid after reset");
      flag_equal(mem_req_o, 1'b0, "memory request after reset");
      flag_equal(reload_busy_o, 1'b0, "busy after reset");
      flag_equal(reload_fault_o, 1'b0, "fault after reset");
      spr_read_check(SPR_IMMUCR, '0, "IMMUCR after reset");
   endtask

   task automatic spr_readback();
      word_t r;
      word_t m;
      word_t t;
      for (int i = 0; i < 8; i++) begin
         r = rand_bits(SET_W);
         m = rand_bits(WORD_W);
         t = rand_bits(WORD_W);
         load_entry(r[SET_W-1:0], m, t);
         spr_read_check(match_spr(r[SET_W-1:0]), m, "match word readback");
         spr_read_check(trans_spr(r[SET_W-1:0]), t, "translate word readback");
      end
      spr_read_check(16'h1100, '0, "unmapped group 2 address");
      spr_read_check(16'h1040, '0, "unmapped group 2 address");
      spr_read_check(16'h12c0, '0, "unmapped group 2 address");
   endtask

   task automatic lookup_hits();
      word_t m;
      word_t t;
      word_t r;
      for (int i = 0; i < 6; i++) begin
         m = rand_bits(WORD_W);
         m[PAGE_LSB +: SET_W] = set_idx_t'(i + 1);
         m[MR_V_BIT] = 1'b1;
         // Permission and cache inhibit patterns follow the entry number
         t = rand_bits(WORD_W);
         t[TR_SXE_BIT] = i[0];
         t[TR_UXE_BIT] = i[1];
         t[TR_CI_BIT]  = i[2];
         load_entry(set_idx_t'(i + 1), m, t);
         r = rand_bits(2 * PAGE_LSB);
         fetch_va.push_back({m[WORD_W-1:PAGE_LSB], r[PAGE_LSB-1:0]});
         fetch_sup.push_back(1'b1);
         fetch_va.push_back({m[WORD_W-1:PAGE_LSB], r[2*PAGE_LSB-1:PAGE_LSB]});
         fetch_sup.push_back(1'b0);
      end
      issue_fetches();
   endtask

   task automatic lookup_misses();
      word_t m;
      word_t va;
      m = rand_bits(WORD_W);
      m[PAGE_LSB +: SET_W] = 6'd10;
      m[MR_V_BIT] = 1'b0;
      load_entry(6'd10, m, rand_bits(WORD_W));
      va = rand_bits(WORD_W);
      va[WORD_W-1:PAGE_LSB] = m[WORD_W-1:PAGE_LSB];
      fetch_va.push_back(va);
      fetch_sup.push_back(1'b1);
      m = rand_bits(WORD_W);
      m[PAGE_LSB +: SET_W] = 6'd11;
      m[MR_V_BIT] = 1'b1;
      load_entry(6'd11, m, rand_bits(WORD_W));
      va = rand_bits(WORD_W);
      va[PAGE_LSB +: SET_W] = 6'd11;
      va[WORD_W-1:PAGE_LSB+SET_W] = ~m[WORD_W-1:PAGE_LSB+SET_W];
      fetch_va.push_back(va);
      fetch_sup.push_back(1'b0);
      walk_addrs.delete();
      issue_fetches();
      repeat (4) begin
         tick();
         flag_equal(mem_req_o, 1'b0, "memory request with IMMUCR at zero");
      end
      word_equal(word_t'(walk_addrs.size()), '0, "memory reads with IMMUCR at zero");
   endtask

   task automatic table_walk();
      word_t va;
      word_t base;
      word_t ptr;
      word_t pte;
      word_t dir_addr;
      word_t pte_addr;
      word_t m_new;
      word_t t_new;
      va = rand_bits(WORD_W);
      va[PAGE_LSB +: SET_W] = 6'd20;
      load_entry(6'd20, '0, '0);
      set_base(base);
      ptr = rand_bits(WORD_W);
      ptr[WORD_W-1] = 1'b1;
      pte = rand_bits(WORD_W);
      pte[PTE_PRESENT_BIT] = 1'b1;
      pte[PTE_X_BIT] = 1'b1;
      dir_addr = {base[WORD_W-1:PT_BASE_LSB], va[WORD_W-1:DIR_IDX_LSB], 2'b00};
      pte_addr = {ptr[WORD_W-1:PAGE_LSB], va[DIR_IDX_LSB-1:PAGE_LSB], 2'b00};
      mem[dir_addr] = ptr;
      mem[pte_addr] = pte;
      walk_addrs.delete();
      fetch_va.push_back(va);
      fetch_sup.push_back(1'b1);
      issue_fetches();
      busy_drop_check(va);
      wait_walk_end(1'b0);
      word_equal(word_t'(walk_addrs.size()), 32'd2, "walker read count");
      if (walk_addrs.size() == 2) begin
         word_equal(walk_addrs[0], dir_addr, "directory read address");
         word_equal(walk_addrs[1], pte_addr, "PTE read address");
      end
      // Entry as the PTE conversion rule gives it
      m_new = {va[WORD_W-1:PAGE_LSB], 12'h000, 1'b1};
      t_new = '0;
      t_new[WORD_W-1:PAGE_LSB] = pte[WORD_W-1:PAGE_LSB];
      t_new[TR_UXE_BIT] = pte[PTE_X_BIT] & pte[PTE_U_BIT];
      t_new[TR_SXE_BIT] = pte[PTE_X_BIT];
      t_new[ATTR_W-1:0] = pte[ATTR_W-1:0];
      match_model[6'd20] = m_new;
      trans_model[6'd20] = t_new;
      fetch_va.push_back(va);
      fetch_sup.push_back(1'b1);
      fetch_va.push_back({va[WORD_W-1:PAGE_LSB], ~va[PAGE_LSB-1:0]});
      fetch_sup.push_back(1'b0);
      issue_fetches();
      spr_read_check(match_spr(6'd20), m_new, "refilled match word");
      spr_read_check(trans_spr(6'd20), t_new, "refilled translate word");
   endtask

   task automatic fault_case(input set_idx_t s, input logic zero_ptr);
      word_t va;
      word_t base;
      word_t m;
      word_t t;
      word_t ptr;
      word_t pte;
      va = rand_bits(WORD_W);
      va[PAGE_LSB +: SET_W] = s;
      m = rand_bits(WORD_W);
      m[MR_V_BIT] = 1'b0;
      t = rand_bits(WORD_W);
      load_entry(s, m, t);
      set_base(base);
      ptr = rand_bits(WORD_W);
      ptr[WORD_W-1] = 1'b1;
      if (zero_ptr) begin
         ptr[WORD_W-1:PAGE_LSB] = '0;
      end
      pte = rand_bits(WORD_W);
      pte[PTE_PRESENT_BIT] = 1'b0;
      mem[{base[WORD_W-1:PT_BASE_LSB], va[WORD_W-1:DIR_IDX_LSB], 2'b00}] = ptr;
      mem[{ptr[WORD_W-1:PAGE_LSB], va[DIR_IDX_LSB-1:PAGE_LSB], 2'b00}] = pte;
      walk_addrs.delete();
      fetch_va.push_back(va);
      fetch_sup.push_back(1'b0);
      issue_fetches();
      wait_walk_end(1'b1);
      word_equal(word_t'(walk_addrs.size()), zero_ptr ? 32'd1 : 32'd2, "reads before fault");
      spr_read_check(match_spr(s), m, "match word after fault");
      spr_read_check(trans_spr(s), t, "translate word after fault");
      flag_equal(reload_fault_o, 1'b1, "fault held before clear");
      reload_fault_clear_i = 1'b1;
      tick();
      reload_fault_clear_i = 1'b0;
      flag_equal(reload_fault_o, 1'b0, "fault after clear");
   endtask

   task automatic walk_faults();
      fault_case(6'd30, 1'b1);
      fault_case(6'd31, 1'b0);
   endtask

   // Memory model acknowledges for one cycle after 0 to 3 wait cycles
   initial begin
      mem_ack_i   = 1'b0;
      mem_rdata_i = '0;
      wait_left   = -1;
      forever begin
         tick();
         if (mem_ack_i) begin
            mem_ack_i = 1'b0;
         end else if (mem_req_o) begin
            if (wait_left < 0) begin
               wait_left = int'(rand_bits(2));
            end
            if (wait_left == 0) begin
               mem_ack_i   = 1'b1;
               mem_rdata_i = mem.exists(mem_addr_o) ? mem[mem_addr_o] : '0;
               walk_addrs.push_back(mem_addr_o);
               wait_left   = -1;
            end else begin
               wait_left--;
            end
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired before the tests finished");
      $display("Test failed");
      $finish;
   end

   initial begin
      value_errors         = 0;
      other_errors         = 0;
      clk                  = 1'b0;
      rst                  = 1'b1;
      enable_i             = 1'b1;
      supervisor_i         = 1'b0;
      fetch_valid_i        = 1'b0;
      fetch_vaddr_i        = '0;
      spr_i                = '0;
      reload_fault_clear_i = 1'b0;
      repeat (10) @(posedge clk);
      #5;
      rst = 1'b0;
      reset_state_check();
      spr_readback();
      lookup_hits();
      lookup_misses();
      table_walk();
      walk_faults();
      $display("Checks done with %0d value errors and %0d other errors",
               value_errors, other_errors);
      if (value_errors + other_errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* list.f */
logic/immu_pkg.sv
logic/itlb_ram.sv
logic/immu_spr_regs.sv
logic/itlb_lookup.sv
logic/itlb_reload_walker.sv
logic/immu_top.sv
testbench/immu_tb.sv

/* Bender.yml */
package:
  name: immu

sources:
  - logic/immu_pkg.sv
  - logic/itlb_ram.sv
  - logic/immu_spr_regs.sv
  - logic/itlb_lookup.sv
  - logic/itlb_reload_walker.sv
  - logic/immu_top.sv
  - target: test
    files:
      - testbench/immu_tb.sv
